//--- common/periph_pkg.sv
// Bus widths, the read address map and pad types; both windows must be aligned to their size
package periph_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	typedef logic [ADDR_WIDTH-1:0] axil_addr_t;
	typedef logic [DATA_WIDTH-1:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	// Address map
	localparam axil_addr_t CONT_BASE = 32'h0200_0200;
	localparam int CONT_ADDR_BITS = 2;
	localparam axil_addr_t SCLK_BASE = 32'h0200_0300;
	localparam int SCLK_ADDR_BITS = 8;

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_DECERR = 2'b11;

	// One tick per 256 cycles of clk_50mhz
	localparam int TICK_DIV_BITS = 9;
	localparam int PAD_BUTTONS = 8;
	localparam int POLL_TICKS = 16;

	// Bit i is the i-th bit shifted out, 1 means pressed
	typedef logic [PAD_BUTTONS-1:0] pad_state_t;

	typedef struct packed {
		pad_state_t pad1;
		pad_state_t pad0;
	} pad_pair_t;

endpackage

//--- common/axil_read_if.sv
// AXI-Lite read channels only; no arprot and no write side
`timescale 1ns/1ps

interface axil_read_if
	import periph_pkg::*;
();
	axil_addr_t araddr;
	logic arvalid;
	logic arready;
	axil_data_t rdata;
	axil_resp_t rresp;
	logic rvalid;
	logic rready;

	modport master (
		output araddr, arvalid, rready,
		input arready, rdata, rresp, rvalid
	);

	modport slave (
		input araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);

endinterface

//--- src/axil_read_port.sv
// Single-register read slave; the address is not decoded and payload_t must fit DATA_WIDTH
`timescale 1ns/1ps

module axil_read_port
	import periph_pkg::*;
#(
	parameter type payload_t = axil_data_t
) (
	input logic clk_50mhz,
	input logic resetn,
	input payload_t payload,
	axil_read_if.slave bus
);

	logic rvalid_q;
	axil_data_t rdata_q;

	// Ready again only once the held response is taken
	assign bus.arready = !rvalid_q;
	assign bus.rvalid = rvalid_q;
	assign bus.rdata = rdata_q;
	assign bus.rresp = RESP_OKAY;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			rvalid_q <= 1'b0;
		else if (bus.arvalid && !rvalid_q)
			rvalid_q <= 1'b1;
		else if (rvalid_q && bus.rready)
			rvalid_q <= 1'b0;
	end

	// Snapshot at address accept, zero-extended
	always_ff @(posedge clk_50mhz) begin
		if (bus.arvalid && !rvalid_q)
			rdata_q <= axil_data_t'(payload);
	end

endmodule

//--- src/system_counter.sv
// Cycle count since reset, wraps at 32 bits; every address in the window reads the same value
`timescale 1ns/1ps

module system_counter
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,
	axil_read_if.slave bus
);

	axil_data_t count_q;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			count_q <= '0;
		else
			count_q <= count_q + 1'b1;
	end

	axil_read_port #(
		.payload_t(axil_data_t)
	) u_port (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.payload(count_q),
		.bus(bus)
	);

endmodule

//--- src/axil_read_decoder.sv
// Serves one read at a time; addresses outside both windows get DECERR with zero data
`timescale 1ns/1ps

module axil_read_decoder
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,

	input axil_addr_t s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output axil_data_t s_axil_rdata,
	output axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,

	axil_read_if.master cont_bus,
	axil_read_if.master sclk_bus
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FORWARD,
		ST_WAIT_RESP,
		ST_ERROR
	} state_t;

	state_t state_q;
	logic sel_sclk_q;
	axil_addr_t addr_q;

	logic cont_hit;
	logic sclk_hit;
	logic sel_arready;
	logic sel_rvalid;

	assign cont_hit = s_axil_araddr[ADDR_WIDTH-1:CONT_ADDR_BITS]
		== CONT_BASE[ADDR_WIDTH-1:CONT_ADDR_BITS];
	assign sclk_hit = s_axil_araddr[ADDR_WIDTH-1:SCLK_ADDR_BITS]
		== SCLK_BASE[ADDR_WIDTH-1:SCLK_ADDR_BITS];

	assign s_axil_arready = (state_q == ST_IDLE);

	// Address phase towards the chosen slave
	assign cont_bus.araddr = addr_q;
	assign sclk_bus.araddr = addr_q;
	assign cont_bus.arvalid = (state_q == ST_FORWARD) && !sel_sclk_q;
	assign sclk_bus.arvalid = (state_q == ST_FORWARD) && sel_sclk_q;
	assign sel_arready = sel_sclk_q ? sclk_bus.arready : cont_bus.arready;

	// Response path
	assign sel_rvalid = sel_sclk_q ? sclk_bus.rvalid : cont_bus.rvalid;
	assign cont_bus.rready = (state_q == ST_WAIT_RESP) && !sel_sclk_q && s_axil_rready;
	assign sclk_bus.rready = (state_q == ST_WAIT_RESP) && sel_sclk_q && s_axil_rready;

	always_comb begin
		s_axil_rvalid = 1'b0;
		s_axil_rdata = '0;
		s_axil_rresp = RESP_OKAY;
		if (state_q == ST_WAIT_RESP) begin
			s_axil_rvalid = sel_rvalid;
			s_axil_rdata = sel_sclk_q ? sclk_bus.rdata : cont_bus.rdata;
			s_axil_rresp = sel_sclk_q ? sclk_bus.rresp : cont_bus.rresp;
		end else if (state_q == ST_ERROR) begin
			s_axil_rvalid = 1'b1;
			s_axil_rresp = RESP_DECERR;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state_q <= ST_IDLE;
			sel_sclk_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (s_axil_arvalid) begin
						sel_sclk_q <= sclk_hit;
						state_q <= (cont_hit || sclk_hit) ? ST_FORWARD : ST_ERROR;
					end
				end
				ST_FORWARD: begin
					if (sel_arready)
						state_q <= ST_WAIT_RESP;
				end
				ST_WAIT_RESP: begin
					if (sel_rvalid && s_axil_rready)
						state_q <= ST_IDLE;
				end
				ST_ERROR: begin
					if (s_axil_rready)
						state_q <= ST_IDLE;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (state_q == ST_IDLE && s_axil_arvalid)
			addr_q <= s_axil_araddr;
	end

endmodule

//--- controller/pad_tick_divider.sv
// Tick strobe every 256 cycles of clk_50mhz, first one 256 cycles after reset
`timescale 1ns/1ps

module pad_tick_divider
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,
	output logic tick
);

	logic [TICK_DIV_BITS-1:0] div_q;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			div_q <= '0;
		else
			div_q <= div_q + 1'b1;
	end

	// Last cycle before the top bit toggles
	assign tick = &div_q[TICK_DIV_BITS-2:0];

endmodule

//--- controller/pad_poller.sv
// Polls both NES-style pads in lockstep; pads refresh once per 16-tick frame, data lines active low
`timescale 1ns/1ps

module pad_poller
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,
	input logic tick,
	input logic c1data,
	input logic c2data,
	output logic c1clock,
	output logic c1latch,
	output logic c2clock,
	output logic c2latch,
	output pad_pair_t pads
);

	logic [$clog2(POLL_TICKS)-1:0] step_q;
	logic latch_q;
	logic pclk_q;
	pad_state_t shift0_q;
	pad_state_t shift1_q;

	assign c1latch = latch_q;
	assign c2latch = latch_q;
	assign c1clock = pclk_q;
	assign c2clock = pclk_q;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			step_q <= '0;
			latch_q <= 1'b0;
			pclk_q <= 1'b0;
			pads <= '0;
		end else if (tick) begin
			if (step_q == POLL_TICKS - 1)
				step_q <= '0;
			else
				step_q <= step_q + 1'b1;

			if (step_q == 0)
				latch_q <= 1'b1;
			else if (step_q == 1)
				latch_q <= 1'b0;
			else
				// Even steps raise the clock, odd ones drop it
				pclk_q <= !step_q[0];

			// Last bit goes straight into the published value
			if (step_q == POLL_TICKS - 1) begin
				pads.pad0 <= ~{c1data, shift0_q[PAD_BUTTONS-1:1]};
				pads.pad1 <= ~{c2data, shift1_q[PAD_BUTTONS-1:1]};
			end
		end
	end

	// Sample on every odd step, first bit ends up in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (tick && step_q[0]) begin
			shift0_q <= {c1data, shift0_q[PAD_BUTTONS-1:1]};
			shift1_q <= {c2data, shift1_q[PAD_BUTTONS-1:1]};
		end
	end

endmodule

//--- src/periph_top.sv
// Read-only peripheral block on clk_50mhz; one read in flight, pads polled about every 82 us
`timescale 1ns/1ps

module periph_top
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,

	input axil_addr_t s_axil_araddr,
	input logic s_axil_arvalid,
	output logic s_axil_arready,
	output axil_data_t s_axil_rdata,
	output axil_resp_t s_axil_rresp,
	output logic s_axil_rvalid,
	input logic s_axil_rready,

	output logic c1clock,
	output logic c1latch,
	input logic c1data,
	output logic c2clock,
	output logic c2latch,
	input logic c2data
);

	axil_read_if cont_bus ();
	axil_read_if sclk_bus ();

	logic tick;
	pad_pair_t pads;

	axil_read_decoder u_decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.cont_bus(cont_bus.master),
		.sclk_bus(sclk_bus.master)
	);

	system_counter u_system_counter (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus(sclk_bus.slave)
	);

	pad_tick_divider u_tick_divider (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.tick(tick)
	);

	pad_poller u_pad_poller (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.tick(tick),
		.c1data(c1data),
		.c2data(c2data),
		.c1clock(c1clock),
		.c1latch(c1latch),
		.c2clock(c2clock),
		.c2latch(c2latch),
		.pads(pads)
	);

	// Controller register, pad1 in 15:8 and pad0 in 7:0
	axil_read_port #(
		.payload_t(pad_pair_t)
	) u_cont_port (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.payload(pads),
		.bus(cont_bus.slave)
	);

endmodule

//--- verification/periph_assert.sv
// Bus and pad protocol checks bound into periph_top; inactive while resetn is low
`timescale 1ns/1ps

module periph_assert
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic resetn,
	input logic s_axil_rvalid,
	input logic s_axil_rready,
	input axil_data_t s_axil_rdata,
	input logic c1clock,
	input logic c1latch,
	input logic c2clock,
	input logic c2latch
);

	// Failed assertions so far
	int fail_count = 0;

	rvalid_held: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
		else begin
			$error("s_axil_rvalid dropped before s_axil_rready");
			fail_count++;
		end

	rdata_stable: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		s_axil_rvalid && !s_axil_rready |=> $stable(s_axil_rdata))
		else begin
			$error("s_axil_rdata changed under back-pressure");
			fail_count++;
		end

	// Latch and clock are separate phases of a frame
	pad_phases: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		!((c1latch && c1clock) || (c2latch && c2clock)))
		else begin
			$error("Pad latch and clock high together");
			fail_count++;
		end

endmodule

bind periph_top periph_assert u_assert (
	.clk_50mhz(clk_50mhz),
	.resetn(resetn),
	.s_axil_rvalid(s_axil_rvalid),
	.s_axil_rready(s_axil_rready),
	.s_axil_rdata(s_axil_rdata),
	.c1clock(c1clock),
	.c1latch(c1latch),
	.c2clock(c2clock),
	.c2latch(c2latch)
);

//--- verification/periph_tb.sv
// Directed tests of periph_top with two serial pad models; every wait gives up after a cycle budget
`timescale 1ns/1ps

module serial_pad
	import periph_pkg::*;
(
	input logic clk_50mhz,
	input logic latch,
	input logic pclk,
	input pad_state_t pattern,
	output logic data
);

	// Released line until the first latch
	pad_state_t shift_q = '0;
	logic pclk_q = 1'b0;

	// Pressed buttons pull the line low
	assign data = ~shift_q[0];

	always @(posedge clk_50mhz) begin
		pclk_q <= pclk;
		if (latch)
			shift_q <= pattern;
		else if (pclk && !pclk_q)
			shift_q <= {1'b0, shift_q[PAD_BUTTONS-1:1]};
	end

endmodule

module periph_tb
	import periph_pkg::*;
();

	localparam int READ_TIMEOUT = 64;
	localparam int CYCLES_PER_FRAME = POLL_TICKS * 256;

	logic clk_50mhz;
	logic resetn;
	axil_addr_t s_axil_araddr;
	logic s_axil_arvalid;
	logic s_axil_arready;
	axil_data_t s_axil_rdata;
	axil_resp_t s_axil_rresp;
	logic s_axil_rvalid;
	logic s_axil_rready;
	logic c1clock;
	logic c1latch;
	logic c1data;
	logic c2clock;
	logic c2latch;
	logic c2data;
	pad_state_t pattern0;
	pad_state_t pattern1;
	logic [31:0] rng_state;

	periph_top i_periph_top (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.s_axil_araddr(s_axil_araddr),
		.s_axil_arvalid(s_axil_arvalid),
		.s_axil_arready(s_axil_arready),
		.s_axil_rdata(s_axil_rdata),
		.s_axil_rresp(s_axil_rresp),
		.s_axil_rvalid(s_axil_rvalid),
		.s_axil_rready(s_axil_rready),
		.c1clock(c1clock),
		.c1latch(c1latch),
		.c1data(c1data),
		.c2clock(c2clock),
		.c2latch(c2latch),
		.c2data(c2data)
	);

	// Port 1 feeds pad0, port 2 feeds pad1
	serial_pad u_pad0 (
		.clk_50mhz(clk_50mhz),
		.latch(c1latch),
		.pclk(c1clock),
		.pattern(pattern0),
		.data(c1data)
	);

	serial_pad u_pad1 (
		.clk_50mhz(clk_50mhz),
		.latch(c2latch),
		.pclk(c2clock),
		.pattern(pattern1),
		.data(c2data)
	);

	always #10 clk_50mhz = ~clk_50mhz;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	// A failed bound assertion ends the run at the next falling edge
	always @(negedge clk_50mhz) begin
		if (i_periph_top.u_assert.fail_count != 0)
			report_failure("A bound assertion failed on the bus or pad signals");
	end

	task automatic load_patterns();
		rng_state = lcg_next(rng_state);
		pattern0 = rng_state[23:16];
		rng_state = lcg_next(rng_state);
		pattern1 = rng_state[23:16];
	endtask

	// Counts latch rises; a frame that starts after the call is complete at the second one
	task automatic wait_frames(input int frames);
		int cycles;
		int seen;
		logic latch_prev;
		cycles = 0;
		seen = 0;
		latch_prev = c1latch;
		while (seen < frames) begin
			@(negedge clk_50mhz);
			if (c1latch && !latch_prev)
				seen++;
			latch_prev = c1latch;
			cycles++;
			if (cycles > (frames + 1) * CYCLES_PER_FRAME)
				report_failure("Timed out waiting for the pad latch pulses");
		end
	endtask

	task automatic read_bus(input axil_addr_t addr, input int hold, output axil_data_t data,
		output axil_resp_t resp);
		int cycles;
		axil_data_t held;
		s_axil_araddr = addr;
		s_axil_arvalid = 1'b1;
		cycles = 0;
		while (!s_axil_arready) begin
			@(negedge clk_50mhz);
			cycles++;
			if (cycles > READ_TIMEOUT)
				report_failure("Timed out waiting for s_axil_arready");
		end
		@(negedge clk_50mhz);
		s_axil_arvalid = 1'b0;
		cycles = 0;
		while (!s_axil_rvalid) begin
			@(negedge clk_50mhz);
			cycles++;
			if (cycles > READ_TIMEOUT)
				report_failure("Timed out waiting for s_axil_rvalid");
		end
		held = s_axil_rdata;
		repeat (hold) begin
			@(negedge clk_50mhz);
			check_value("s_axil_rvalid", s_axil_rvalid, 1);
			check_value("s_axil_rdata", s_axil_rdata, held);
		end
		data = s_axil_rdata;
		resp = s_axil_rresp;
		s_axil_rready = 1'b1;
		@(negedge clk_50mhz);
		s_axil_rready = 1'b0;
	endtask

	task automatic check_reset_state();
		check_value("s_axil_rvalid", s_axil_rvalid, 0);
		check_value("s_axil_arready", s_axil_arready, 1);
		check_value("c1latch", c1latch, 0);
		check_value("c2latch", c2latch, 0);
		check_value("c1clock", c1clock, 0);
		check_value("c2clock", c2clock, 0);
	endtask

	task automatic read_pads(input int hold);
		axil_data_t data;
		axil_resp_t resp;
		read_bus(CONT_BASE, hold, data, resp);
		check_value("s_axil_rdata", data, {16'h0, pattern1, pattern0});
		check_value("s_axil_rresp", resp, RESP_OKAY);
	endtask

	task automatic read_counter();
		axil_data_t first;
		axil_data_t second;
		axil_resp_t resp;
		read_bus(SCLK_BASE, 0, first, resp);
		check_value("s_axil_rresp", resp, RESP_OKAY);
		read_bus(SCLK_BASE, 0, second, resp);
		check_value("s_axil_rresp", resp, RESP_OKAY);
		check_value("counter increase", second > first, 1);
	endtask

	task automatic read_unmapped();
		axil_data_t data;
		axil_resp_t resp;
		read_bus(32'h0000_1000, 0, data, resp);
		check_value("s_axil_rresp", resp, RESP_DECERR);
		check_value("s_axil_rdata", data, 0);
	endtask

	initial begin
		clk_50mhz = 1'b0;
		resetn = 1'b0;
		s_axil_araddr = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready = 1'b0;
		pattern0 = '0;
		pattern1 = '0;
		rng_state = 32'hd0360c03;
		repeat (2) @(negedge clk_50mhz);
		resetn = 1'b1;

		check_reset_state();
		load_patterns();
		wait_frames(2);
		read_pads(0);
		load_patterns();
		wait_frames(2);
		read_pads(0);
		read_counter();
		read_unmapped();
		read_pads(7);

		if (i_periph_top.u_assert.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "Bound assertions failed");
		end
	end

endmodule

//--- build.f
common/periph_pkg.sv
common/axil_read_if.sv
src/axil_read_port.sv
src/system_counter.sv
src/axil_read_decoder.sv
controller/pad_tick_divider.sv
controller/pad_poller.sv
src/periph_top.sv
verification/periph_assert.sv
verification/periph_tb.sv
